// File: rtl/MulDivPkg.sv
// Shared widths, operation codes, divider phases and bus structs for the multiply/divide block
package MulDivPkg;

    // Datapath sizing
    localparam int DATA_WIDTH = 32;
    localparam int TAG_WIDTH = 6;
    localparam int MUL_DEPTH = 3;
    localparam int DIV_CYCLES = DATA_WIDTH;

    // Operands widened by one bit so that signed and unsigned share one multiplier
    localparam int EXT_WIDTH = DATA_WIDTH + 1;
    localparam int PRODUCT_WIDTH = 2 * EXT_WIDTH;

    // Divider iteration counter
    localparam int DIV_COUNT_WIDTH = $clog2(DIV_CYCLES);
    typedef logic [DIV_COUNT_WIDTH-1:0] DivCount;
    localparam DivCount DIV_LAST_STEP = DivCount'(DIV_CYCLES - 1);

    // Low two bits of funct3 for MUL, MULH, MULHSU, MULHU
    typedef enum logic [1:0] {
        MUL_LOW     = 2'd0,
        MUL_HIGH_SS = 2'd1,
        MUL_HIGH_SU = 2'd2,
        MUL_HIGH_UU = 2'd3
    } MulCode;

    // Low two bits of funct3 for DIV, DIVU, REM, REMU
    typedef enum logic [1:0] {
        DIV_SIGNED   = 2'd0,
        DIV_UNSIGNED = 2'd1,
        REM_SIGNED   = 2'd2,
        REM_UNSIGNED = 2'd3
    } DivCode;

    typedef enum logic [1:0] {
        PHASE_FREE       = 2'd0,  // nobody owns the divider
        PHASE_RESERVED   = 2'd1,  // owned, operands not yet sent
        PHASE_PROCESSING = 2'd2,
        PHASE_WAITING    = 2'd3   // result ready, waiting for the bus
    } DividerPhase;

    typedef struct packed {
        logic                  valid;
        logic [TAG_WIDTH-1:0]  tag;
        MulCode                code;
        logic [DATA_WIDTH-1:0] opA;
        logic [DATA_WIDTH-1:0] opB;
    } MulIssue;

    typedef struct packed {
        logic                  valid;
        logic [TAG_WIDTH-1:0]  tag;
        DivCode                code;
        logic [DATA_WIDTH-1:0] opA;
        logic [DATA_WIDTH-1:0] opB;
    } DivIssue;

    // Writeback bus format shared by both units
    typedef struct packed {
        logic                  valid;
        logic [TAG_WIDTH-1:0]  tag;
        logic [DATA_WIDTH-1:0] data;
    } ExecResult;

endpackage

// File: rtl/PipelinedMultiplier.sv
// Multiplier pipeline of MUL_DEPTH stages that carries the tag and freezes while stalled
module PipelinedMultiplier (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  stall,
    input  MulDivPkg::MulIssue    issue,
    output MulDivPkg::ExecResult  out
);

    // First stage holds the widened operands
    typedef struct packed {
        logic                                valid;
        logic [MulDivPkg::TAG_WIDTH-1:0]     tag;
        MulDivPkg::MulCode                   code;
        logic signed [MulDivPkg::EXT_WIDTH-1:0] opA;
        logic signed [MulDivPkg::EXT_WIDTH-1:0] opB;
    } OperandStage;

    // Later stages carry the full product
    typedef struct packed {
        logic                                    valid;
        logic [MulDivPkg::TAG_WIDTH-1:0]         tag;
        MulDivPkg::MulCode                       code;
        logic [MulDivPkg::PRODUCT_WIDTH-1:0]     product;
    } ProductStage;

    OperandStage operandIn;
    OperandStage operandStage;
    ProductStage productIn;
    ProductStage productStage [MulDivPkg::MUL_DEPTH-1];
    ProductStage lastStage;

    logic signExtA;
    logic signExtB;
    logic signed [MulDivPkg::PRODUCT_WIDTH-1:0] fullProduct;

    // MULHU treats both as unsigned, MULHSU only the second one
    always_comb begin
        signExtA = (issue.code != MulDivPkg::MUL_HIGH_UU);
        signExtB = (issue.code == MulDivPkg::MUL_HIGH_SS) ||
                   (issue.code == MulDivPkg::MUL_LOW);

        operandIn.valid = issue.valid;
        operandIn.tag   = issue.tag;
        operandIn.code  = issue.code;
        operandIn.opA   = {signExtA & issue.opA[MulDivPkg::DATA_WIDTH-1], issue.opA};
        operandIn.opB   = {signExtB & issue.opB[MulDivPkg::DATA_WIDTH-1], issue.opB};
    end

    // 33x33 signed multiply covers every code
    assign fullProduct = $signed(operandStage.opA) * $signed(operandStage.opB);

    always_comb begin
        productIn.valid   = operandStage.valid;
        productIn.tag     = operandStage.tag;
        productIn.code    = operandStage.code;
        productIn.product = fullProduct;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            operandStage.valid <= 1'b0;
            for (int i = 0; i < MulDivPkg::MUL_DEPTH - 1; i++) begin
                productStage[i].valid <= 1'b0;
            end
        end
        else if (!stall) begin
            operandStage    <= operandIn;
            productStage[0] <= productIn;
            for (int i = 1; i < MulDivPkg::MUL_DEPTH - 1; i++) begin
                productStage[i] <= productStage[i-1];
            end
        end
    end

    // Word select in the last stage
    always_comb begin
        lastStage = productStage[MulDivPkg::MUL_DEPTH-2];
        out.valid = lastStage.valid;
        out.tag   = lastStage.tag;
        if (lastStage.code == MulDivPkg::MUL_LOW) begin
            out.data = lastStage.product[MulDivPkg::DATA_WIDTH-1:0];
        end
        else begin
            out.data = lastStage.product[2*MulDivPkg::DATA_WIDTH-1:MulDivPkg::DATA_WIDTH];
        end
    end

endmodule

// File: rtl/IterativeDivider.sv
// Restoring radix-2 divider, one quotient bit per cycle, with RISC-V divide special cases
module IterativeDivider (
    input  logic                  clk,
    input  logic                  rstN,
    input  MulDivPkg::DivIssue    issue,
    input  logic                  kill,
    output logic                  finished,
    output MulDivPkg::ExecResult  out
);

    // Captured at issue and held until the next request
    typedef struct packed {
        logic [MulDivPkg::TAG_WIDTH-1:0]  tag;
        MulDivPkg::DivCode                code;
        logic                             negA;
        logic                             negB;
        logic                             divByZero;
        logic                             overflow;
        logic [MulDivPkg::DATA_WIDTH-1:0] dividend;
        logic [MulDivPkg::DATA_WIDTH-1:0] divisor;
    } DivContext;

    localparam logic [MulDivPkg::DATA_WIDTH-1:0] MOST_NEGATIVE =
        {1'b1, {(MulDivPkg::DATA_WIDTH-1){1'b0}}};

    DivContext contextIn;
    DivContext savedContext;

    logic                               running;
    logic                               finishedReg;
    MulDivPkg::DivCount                 stepCount;
    logic [MulDivPkg::DATA_WIDTH-1:0]   quotReg;
    logic [MulDivPkg::DATA_WIDTH-1:0]   remReg;

    logic                               isSigned;
    logic [MulDivPkg::DATA_WIDTH:0]     shifted;
    logic [MulDivPkg::DATA_WIDTH+1:0]   diff;
    logic [MulDivPkg::DATA_WIDTH-1:0]   quotient;
    logic [MulDivPkg::DATA_WIDTH-1:0]   remainder;

    always_comb begin
        isSigned = (issue.code == MulDivPkg::DIV_SIGNED) ||
                   (issue.code == MulDivPkg::REM_SIGNED);

        contextIn.tag       = issue.tag;
        contextIn.code      = issue.code;
        contextIn.negA      = isSigned & issue.opA[MulDivPkg::DATA_WIDTH-1];
        contextIn.negB      = isSigned & issue.opB[MulDivPkg::DATA_WIDTH-1];
        contextIn.divByZero = (issue.opB == '0);
        contextIn.overflow  = isSigned && (issue.opA == MOST_NEGATIVE) && (issue.opB == '1);
        contextIn.dividend  = issue.opA;
        contextIn.divisor   = contextIn.negB ? -issue.opB : issue.opB;
    end

    // Trial subtraction with the borrow in the top bit of diff
    assign shifted = {remReg, quotReg[MulDivPkg::DATA_WIDTH-1]};
    assign diff    = {1'b0, shifted} - {2'b00, savedContext.divisor};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            running     <= 1'b0;
            finishedReg <= 1'b0;
            stepCount   <= '0;
        end
        else if (kill) begin
            running     <= 1'b0;
            finishedReg <= 1'b0;
        end
        else if (issue.valid) begin
            running     <= 1'b1;
            finishedReg <= 1'b0;
            stepCount   <= '0;
        end
        else if (running) begin
            stepCount <= stepCount + 1'b1;
            if (stepCount == MulDivPkg::DIV_LAST_STEP) begin
                running     <= 1'b0;
                finishedReg <= 1'b1;
            end
        end
        else begin
            finishedReg <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue.valid) begin
            savedContext <= contextIn;
            quotReg      <= contextIn.negA ? -issue.opA : issue.opA;
            remReg       <= '0;
        end
        else if (running) begin
            if (!diff[MulDivPkg::DATA_WIDTH+1]) begin
                remReg  <= diff[MulDivPkg::DATA_WIDTH-1:0];
                quotReg <= {quotReg[MulDivPkg::DATA_WIDTH-2:0], 1'b1};
            end
            else begin
                remReg  <= shifted[MulDivPkg::DATA_WIDTH-1:0];
                quotReg <= {quotReg[MulDivPkg::DATA_WIDTH-2:0], 1'b0};
            end
        end
    end

    // Sign fix-up, then the architectural overrides
    always_comb begin
        quotient  = (savedContext.negA ^ savedContext.negB) ? -quotReg : quotReg;
        remainder = savedContext.negA ? -remReg : remReg;
        if (savedContext.divByZero) begin
            quotient  = '1;
            remainder = savedContext.dividend;
        end
        else if (savedContext.overflow) begin
            quotient  = savedContext.dividend;
            remainder = '0;
        end
    end

    assign finished  = finishedReg;
    assign out.valid = finishedReg;
    assign out.tag   = savedContext.tag;
    assign out.data  = ((savedContext.code == MulDivPkg::REM_SIGNED) ||
                        (savedContext.code == MulDivPkg::REM_UNSIGNED)) ? remainder : quotient;

endmodule

// File: rtl/DividerPhaseTracker.sv
// Reservation FSM for the single divider, with flush override and status decode
module DividerPhaseTracker (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    acquire,
    input  logic                    request,
    input  logic                    finished,
    input  logic                    releaseReq,
    input  logic                    flush,
    output MulDivPkg::DividerPhase  phase,
    output logic                    kill,
    output logic                    free,
    output logic                    reserved,
    output logic                    busy,
    output logic                    waiting
);

    MulDivPkg::DividerPhase nextPhase;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= MulDivPkg::PHASE_FREE;
        end
        else begin
            phase <= nextPhase;
        end
    end

    always_comb begin
        nextPhase = phase;
        case (phase)
            MulDivPkg::PHASE_FREE: begin
                if (acquire) begin
                    nextPhase = MulDivPkg::PHASE_RESERVED;
                end
            end
            MulDivPkg::PHASE_RESERVED: begin
                // Operands arrive with the request
                if (request) begin
                    nextPhase = MulDivPkg::PHASE_PROCESSING;
                end
            end
            MulDivPkg::PHASE_PROCESSING: begin
                if (finished) begin
                    nextPhase = MulDivPkg::PHASE_WAITING;
                end
            end
            MulDivPkg::PHASE_WAITING: begin
                // Result went out on the bus
                if (releaseReq) begin
                    nextPhase = MulDivPkg::PHASE_FREE;
                end
            end
            default: begin
                nextPhase = MulDivPkg::PHASE_FREE;
            end
        endcase

        // Flush wins over everything
        if (flush) begin
            nextPhase = MulDivPkg::PHASE_FREE;
        end
    end

    // Abort only matters while the datapath is iterating
    assign kill = flush && (phase == MulDivPkg::PHASE_PROCESSING);

    // Acquire comes from issue, so free looks one cycle ahead
    assign free     = (nextPhase == MulDivPkg::PHASE_FREE);
    assign reserved = (phase == MulDivPkg::PHASE_RESERVED);
    assign busy     = (phase == MulDivPkg::PHASE_PROCESSING);
    assign waiting  = (phase == MulDivPkg::PHASE_WAITING);

endmodule

// File: rtl/WritebackArbiter.sv
// Fixed-priority writeback select between the multiplier and the waiting divider
module WritebackArbiter (
    input  logic                    wbReady,
    input  MulDivPkg::ExecResult    mulOut,
    input  MulDivPkg::ExecResult    divOut,
    input  MulDivPkg::DividerPhase  phase,
    output MulDivPkg::ExecResult    result,
    output logic                    divRelease
);

    logic mulGrant;
    logic divGrant;

    // Multiplier has fixed latency so it always goes first
    assign mulGrant = wbReady && mulOut.valid;

    // Divider result is held in its registers, so the phase alone tells it is ready
    assign divGrant = wbReady && !mulOut.valid && (phase == MulDivPkg::PHASE_WAITING);

    always_comb begin
        result.valid = mulGrant || divGrant;
        if (divGrant) begin
            result.tag  = divOut.tag;
            result.data = divOut.data;
        end
        else begin
            result.tag  = mulOut.tag;
            result.data = mulOut.data;
        end
    end

    assign divRelease = divGrant;

endmodule

// File: rtl/MulDivUnit.sv
// Top of the multiply/divide execution block, sharing one writeback bus between both units
module MulDivUnit (
    input  logic                  clk,
    input  logic                  rstN,
    input  MulDivPkg::MulIssue    mulIssue,
    input  MulDivPkg::DivIssue    divIssue,
    input  logic                  divAcquire,
    input  logic                  divFlush,
    input  logic                  wbReady,
    output MulDivPkg::ExecResult  result,
    output logic                  divFree,
    output logic                  divReserved,
    output logic                  divBusy,
    output logic                  divWaiting
);

    MulDivPkg::ExecResult   mulOut;
    MulDivPkg::ExecResult   divOut;
    MulDivPkg::DividerPhase phase;
    logic                   mulStall;
    logic                   finished;
    logic                   divKill;
    logic                   divRelease;

    // Back-pressure freezes the multiplier pipe
    assign mulStall = !wbReady;

    PipelinedMultiplier i_PipelinedMultiplier (
        .clk   (clk),
        .rstN  (rstN),
        .stall (mulStall),
        .issue (mulIssue),
        .out   (mulOut)
    );

    IterativeDivider i_IterativeDivider (
        .clk      (clk),
        .rstN     (rstN),
        .issue    (divIssue),
        .kill     (divKill),
        .finished (finished),
        .out      (divOut)
    );

    DividerPhaseTracker i_DividerPhaseTracker (
        .clk        (clk),
        .rstN       (rstN),
        .acquire    (divAcquire),
        .request    (divIssue.valid),
        .finished   (finished),
        .releaseReq (divRelease),
        .flush      (divFlush),
        .phase      (phase),
        .kill       (divKill),
        .free       (divFree),
        .reserved   (divReserved),
        .busy       (divBusy),
        .waiting    (divWaiting)
    );

    WritebackArbiter i_WritebackArbiter (
        .wbReady    (wbReady),
        .mulOut     (mulOut),
        .divOut     (divOut),
        .phase      (phase),
        .result     (result),
        .divRelease (divRelease)
    );

endmodule

// File: sim/mulDivUnit_chk.sv
// Concurrent checks on the writeback bus and the divider phase, bound into the top level
module mulDivUnitChk (
    input logic                   clk,
    input logic                   rstN,
    input logic                   wbReady,
    input MulDivPkg::ExecResult   result,
    input MulDivPkg::DividerPhase phase,
    input logic                   divBusy,
    input logic                   divWaiting
);
    timeunit 1ns;
    timeprecision 1ps;

    int failCount = 0;

    // Nothing is written back while the consumer stalls
    noResultWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        !wbReady |-> !result.valid)
        else begin
            failCount++;
            $error("result.valid high while wbReady low");
        end

    // Processing is only reached through the reserved phase
    noFreeToProcessing: assert property (@(posedge clk) disable iff (!rstN)
        (phase == MulDivPkg::PHASE_FREE) |=> (phase != MulDivPkg::PHASE_PROCESSING))
        else begin
            failCount++;
            $error("divider phase went from free straight to processing");
        end

    busyWaitingExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(divBusy && divWaiting))
        else begin
            failCount++;
            $error("divBusy and divWaiting high together");
        end

endmodule

bind MulDivUnit mulDivUnitChk i_mulDivUnitChk (
    .clk        (clk),
    .rstN       (rstN),
    .wbReady    (wbReady),
    .result     (result),
    .phase      (phase),
    .divBusy    (divBusy),
    .divWaiting (divWaiting)
);

// File: sim/MulDivUnitTb.sv
// Random testbench for the multiply/divide block, run with the checker bound in via tb.f
module MulDivUnitTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int RESET_CYCLES = 10;
    localparam int TEST_CYCLES = 2000;
    localparam int W = MulDivPkg::DATA_WIDTH;
    localparam int TAG_W = MulDivPkg::TAG_WIDTH;
    localparam int TAG_COUNT = 2 ** TAG_W;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + MulDivPkg::DIV_CYCLES * 4;
    localparam logic [W-1:0] MOST_NEGATIVE = {1'b1, {(W-1){1'b0}}};

    logic clk = 1'b0;
    logic rstN;
    MulDivPkg::MulIssue mulIssue;
    MulDivPkg::DivIssue divIssue;
    logic divAcquire;
    logic divFlush;
    logic wbReady;
    MulDivPkg::ExecResult result;
    logic divFree;
    logic divReserved;
    logic divBusy;
    logic divWaiting;

    // Scoreboard indexed by tag
    logic pending [TAG_COUNT];
    logic isMul [TAG_COUNT];
    logic [W-1:0] expected [TAG_COUNT];
    int readyEdges [TAG_COUNT];
    int outstanding = 0;
    int nextTag = 0;
    int divTag = -1;
    int valueErrors = 0;
    int protocolErrors = 0;
    logic acquiredPrev = 1'b0;
    logic issuedPrev = 1'b0;
    logic flushedPrev = 1'b0;
    logic divRetiredPrev = 1'b0;

    MulDivUnit i_MulDivUnit (
        .clk         (clk),
        .rstN        (rstN),
        .mulIssue    (mulIssue),
        .divIssue    (divIssue),
        .divAcquire  (divAcquire),
        .divFlush    (divFlush),
        .wbReady     (wbReady),
        .result      (result),
        .divFree     (divFree),
        .divReserved (divReserved),
        .divBusy     (divBusy),
        .divWaiting  (divWaiting)
    );

    always begin
        #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Corner values show up far more often than uniform draws would give
    function automatic logic [W-1:0] randomOperand();
        case ($urandom_range(0, 7))
            0: return '0;
            1: return '1;
            2: return MOST_NEGATIVE;
            3: return 1;
            default: return $urandom();
        endcase
    endfunction

    // Full 64-bit product and then the selected word
    function automatic logic [W-1:0] mulExpected(MulDivPkg::MulCode code, logic [W-1:0] a,
                                                 logic [W-1:0] b);
        logic [2*W-1:0] wideA;
        logic [2*W-1:0] wideB;
        logic [2*W-1:0] product;
        wideA = {{W{1'b0}}, a};
        wideB = {{W{1'b0}}, b};
        if (code == MulDivPkg::MUL_HIGH_SS || code == MulDivPkg::MUL_HIGH_SU) begin
            wideA = {{W{a[W-1]}}, a};
        end
        if (code == MulDivPkg::MUL_HIGH_SS) begin
            wideB = {{W{b[W-1]}}, b};
        end
        product = wideA * wideB;
        return (code == MulDivPkg::MUL_LOW) ? product[W-1:0] : product[2*W-1:W];
    endfunction

    // Signed overflow falls out of the wide divide and only divide by zero needs a rule
    function automatic logic [W-1:0] divExpected(MulDivPkg::DivCode code, logic [W-1:0] a,
                                                 logic [W-1:0] b);
        longint dividend;
        longint divisor;
        longint quotient;
        longint remainder;
        if (code == MulDivPkg::DIV_SIGNED || code == MulDivPkg::REM_SIGNED) begin
            dividend = longint'($signed(a));
            divisor = longint'($signed(b));
        end
        else begin
            dividend = longint'(a);
            divisor = longint'(b);
        end
        if (b == '0) begin
            quotient = -1;
            remainder = dividend;
        end
        else begin
            quotient = dividend / divisor;
            remainder = dividend % divisor;
        end
        if (code == MulDivPkg::REM_SIGNED || code == MulDivPkg::REM_UNSIGNED) begin
            return remainder[W-1:0];
        end
        return quotient[W-1:0];
    endfunction

    function automatic int allocateTag();
        int tag;
        tag = -1;
        for (int i = 0; i < TAG_COUNT && tag < 0; i++) begin
            if (!pending[(nextTag + i) % TAG_COUNT]) begin
                tag = (nextTag + i) % TAG_COUNT;
            end
        end
        nextTag = (tag + 1) % TAG_COUNT;
        return tag;
    endfunction

    task automatic recordOp(int tag, logic mulOp, logic [W-1:0] value);
        expected[tag] = value;
        isMul[tag] = mulOp;
        readyEdges[tag] = 0;
        pending[tag] = 1'b1;
        outstanding++;
    endtask

    // Remember last cycle's strobes, then drop them
    task automatic clearInputs();
        acquiredPrev = divAcquire;
        issuedPrev = divIssue.valid;
        flushedPrev = divFlush;
        mulIssue = '0;
        divIssue = '0;
        divAcquire = 1'b0;
        divFlush = 1'b0;
    endtask

    task automatic driveRandom();
        int tag;
        logic phaseFree;
        clearInputs();
        wbReady = ($urandom_range(0, 9) >= 2);
        // Multiplies only enter while the pipe advances
        if (wbReady && $urandom_range(0, 2) != 0) begin
            tag = allocateTag();
            mulIssue.valid = 1'b1;
            mulIssue.tag = TAG_W'(tag);
            mulIssue.code = MulDivPkg::MulCode'($urandom_range(0, 3));
            mulIssue.opA = randomOperand();
            mulIssue.opB = randomOperand();
            recordOp(tag, 1'b1, mulExpected(mulIssue.code, mulIssue.opA, mulIssue.opB));
        end
        phaseFree = !divReserved && !divBusy && !divWaiting;
        // No flush while a waiting divide could be granted in the same cycle
        if ($urandom_range(0, 49) == 0 && !(divWaiting && wbReady)) begin
            divFlush = 1'b1;
            if (divTag >= 0) begin
                pending[divTag] = 1'b0;
                outstanding--;
                divTag = -1;
            end
        end
        else if (phaseFree && !flushedPrev && $urandom_range(0, 1) == 1) begin
            divAcquire = 1'b1;
        end
        else if (divReserved && $urandom_range(0, 1) == 1) begin
            tag = allocateTag();
            divIssue.valid = 1'b1;
            divIssue.tag = TAG_W'(tag);
            divIssue.code = MulDivPkg::DivCode'($urandom_range(0, 3));
            divIssue.opA = randomOperand();
            divIssue.opB = randomOperand();
            case ($urandom_range(0, 5))
                0: divIssue.opB = '0;
                1: begin
                    divIssue.opA = MOST_NEGATIVE;
                    divIssue.opB = '1;
                end
                default: ;
            endcase
            recordOp(tag, 1'b0, divExpected(divIssue.code, divIssue.opA, divIssue.opB));
            divTag = tag;
        end
    endtask

    // Called mid-cycle, after inputs and the result bus have settled
    task automatic scoreCycle();
        int tag;
        tag = result.tag;
        if (acquiredPrev) begin
            assert (divReserved) else begin
                protocolErrors++;
                $display("Divider not reserved after acquire at %0t", $time);
            end
        end
        if (issuedPrev) begin
            assert (divBusy) else begin
                protocolErrors++;
                $display("Divider not busy after divide issue at %0t", $time);
            end
        end
        if (flushedPrev) begin
            assert (divFree && !divReserved && !divBusy && !divWaiting) else begin
                protocolErrors++;
                $display("Divider not free in the cycle after a flush at %0t", $time);
            end
        end
        // The phase returns to free once the divide result has gone out
        if (divRetiredPrev) begin
            assert (!divReserved && !divBusy && !divWaiting) else begin
                protocolErrors++;
                $display("Divider not free in the cycle after its result at %0t", $time);
            end
        end
        divRetiredPrev = 1'b0;
        if (result.valid) begin
            assert (pending[tag]) else begin
                protocolErrors++;
                $display("Result with unknown or flushed tag %0d at %0t", tag, $time);
            end
            if (pending[tag]) begin
                assert (result.data === expected[tag]) else begin
                    valueErrors++;
                    $display("FAIL time=%0t result.data tag=%0d expected=%h actual=%h",
                             $time, tag, expected[tag], result.data);
                end
                if (isMul[tag]) begin
                    assert (readyEdges[tag] == MulDivPkg::MUL_DEPTH) else begin
                        valueErrors++;
                        $display("FAIL time=%0t multiply latency tag=%0d expected=%0d actual=%0d",
                                 $time, tag, MulDivPkg::MUL_DEPTH, readyEdges[tag]);
                    end
                end
                else begin
                    assert (divWaiting) else begin
                        protocolErrors++;
                        $display("Divide result sent outside the waiting phase at %0t", $time);
                    end
                    divTag = -1;
                    divRetiredPrev = 1'b1;
                end
                pending[tag] = 1'b0;
                outstanding--;
            end
        end
        // Count the coming edge for every multiply still in the pipe
        for (int t = 0; t < TAG_COUNT; t++) begin
            if (pending[t] && isMul[t] && wbReady) begin
                assert (readyEdges[t] < MulDivPkg::MUL_DEPTH) else begin
                    protocolErrors++;
                    $display("Multiply with tag %0d missing from the bus at %0t", t, $time);
                end
                readyEdges[t]++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h850f));
        foreach (pending[t]) begin
            pending[t] = 1'b0;
        end
        rstN = 1'b0;
        mulIssue = '0;
        divIssue = '0;
        divAcquire = 1'b0;
        divFlush = 1'b0;
        wbReady = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rstN = 1'b1;
        @(negedge clk);
        assert (!result.valid && divFree && !divReserved && !divBusy && !divWaiting) else begin
            protocolErrors++;
            $display("Outputs not in their reset state at %0t", $time);
        end
        for (int cycle = 0; cycle < TEST_CYCLES; cycle++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            driveRandom();
            @(negedge clk);
            scoreCycle();
        end
        // Drain with the bus always ready
        while (outstanding > 0) begin
            @(posedge clk);
            #DRIVE_DELAY;
            clearInputs();
            wbReady = 1'b1;
            @(negedge clk);
            scoreCycle();
        end
        $display("Errors: value=%0d protocol=%0d assertion=%0d", valueErrors, protocolErrors,
                 i_MulDivUnit.i_mulDivUnitChk.failCount);
        if (valueErrors == 0 && protocolErrors == 0 &&
            i_MulDivUnit.i_mulDivUnitChk.failCount == 0) begin
            $display("STATUS: PASS");
        end
        else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles with %0d operations outstanding",
                 WATCHDOG_CYCLES, outstanding);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: tb.f
rtl/MulDivPkg.sv
rtl/PipelinedMultiplier.sv
rtl/IterativeDivider.sv
rtl/DividerPhaseTracker.sv
rtl/WritebackArbiter.sv
rtl/MulDivUnit.sv
sim/mulDivUnit_chk.sv
sim/MulDivUnitTb.sv
